// File: umi_pkg.sv
/*
 * UMI packet definitions shared by the register endpoint.
 * Holds the bus widths, the opcode encoding, the command word layout
 * and the request/response packet structs used on the device port.
 */

package umi_pkg;

   //##################################################
   // Bus widths
   //##################################################

   localparam int UMI_CW = 32;      // Command word
   localparam int UMI_AW = 64;      // Address
   localparam int UMI_DW = 128;     // Packet data

   //##################################################
   // Opcodes
   //##################################################

   // Only the opcodes this endpoint cares about
   typedef enum logic [4:0] {
      INVALID    = 5'd0,
      REQ_READ   = 5'd1,
      RESP_READ  = 5'd2,
      REQ_WRITE  = 5'd3,
      RESP_WRITE = 5'd4,
      REQ_POSTED = 5'd5,
      REQ_ATOMIC = 5'd9
   } umi_opcode_e;

   //##################################################
   // Command word and packets
   //##################################################

   // Field order is MSB first, 32 bits in total
   typedef struct packed {
      logic [4:0]  hostid;          // Requesting host
      logic [1:0]  user;            // User bits
      logic        ex;              // Exclusive access
      logic        eof;             // End of frame
      logic        eom;             // End of message
      logic [1:0]  prot;            // Protection mode
      logic [3:0]  qos;             // Quality of service
      logic [7:0]  len;             // Beats minus one
      logic [2:0]  size;            // Log2 of bytes per beat
      umi_opcode_e opcode;
   } umi_cmd_t;

   // Request packet, host to device
   typedef struct packed {
      umi_cmd_t              cmd;
      logic [UMI_AW-1:0]     dstaddr;   // Target address
      logic [UMI_AW-1:0]     srcaddr;   // Return address
      logic [UMI_DW-1:0]     data;
   } umi_req_t;

   // Response packet, device to host
   typedef struct packed {
      umi_cmd_t              cmd;
      logic [UMI_AW-1:0]     dstaddr;   // Copied from request srcaddr
      logic [UMI_AW-1:0]     srcaddr;   // Always zero here
      logic [UMI_DW-1:0]     data;
   } umi_resp_t;

endpackage

// File: regif_pkg.sv
/*
 * Register endpoint constants and the internal register bus.
 * Group decode, register count, response queue depth and ID value.
 */

package regif_pkg;

   localparam int REG_W = 32;                  // Register width

   // Group field inside the destination address
   localparam int             GRP_OFFSET = 24;
   localparam int             GRP_AW     = 4;
   localparam logic [GRP_AW-1:0] GRP_ID  = 4'h3;   // This endpoint

   localparam int          NUM_REGS   = 16;        // Index is addr[5:2]
   localparam logic [REG_W-1:0] ID_VALUE = 32'h5245_4749;   // Reg 0, read only
   localparam int          RESP_DEPTH = 4;         // Response queue entries

   // Strobes plus the request fields they act on
   typedef struct packed {
      logic                      read;      // One-cycle read strobe
      logic                      write;     // One-cycle write strobe
      logic [umi_pkg::UMI_AW-1:0] addr;
      logic [2:0]                size;
      logic [7:0]                len;
      logic [REG_W-1:0]          wrdata;
   } reg_bus_t;

endpackage

// File: umi_regif.sv
/*
 * UMI request translator. Turns accepted read, write and posted-write
 * requests into single-cycle register strobes and builds the matching
 * response packet, which is pushed into the response queue.
 */

`timescale 1ns/100ps

module umi_regif
  (
   input  logic                        clk,
   input  logic                        nreset,
   // UMI request side
   input  logic                        udev_req_valid,
   input  umi_pkg::umi_req_t           udev_req,
   output logic                        udev_req_ready,
   // Response queue status
   input  logic                        full,
   // Register bus
   output regif_pkg::reg_bus_t         reg_bus,
   input  logic [regif_pkg::REG_W-1:0] reg_rddata,
   // Response queue write side
   output logic                        push,
   output umi_pkg::umi_resp_t          push_data
   );

   import umi_pkg::*;
   import regif_pkg::*;

   logic accept;        // Request transfer this cycle
   logic group_match;
   logic is_read;
   logic is_write;
   logic is_posted;

   //##################################################
   // Request decode
   //##################################################

   // Stall everything while the queue is full
   assign udev_req_ready = ~full;
   assign accept         = udev_req_valid & udev_req_ready;

   assign group_match = (udev_req.dstaddr[GRP_OFFSET +: GRP_AW] == GRP_ID);

   // Atomics and anything else fall through and get dropped
   always_comb
   begin
      is_read   = 1'b0;
      is_write  = 1'b0;
      is_posted = 1'b0;
      case (udev_req.cmd.opcode)
         REQ_READ:   is_read   = 1'b1;
         REQ_WRITE:  is_write  = 1'b1;
         REQ_POSTED: is_posted = 1'b1;
         default:    ;
      endcase
   end

   //##################################################
   // Register bus
   //##################################################

   assign reg_bus.read   = accept & group_match & is_read;
   assign reg_bus.write  = accept & group_match & (is_write | is_posted);
   assign reg_bus.addr   = udev_req.dstaddr;
   assign reg_bus.size   = udev_req.cmd.size;
   assign reg_bus.len    = udev_req.cmd.len;
   assign reg_bus.wrdata = udev_req.data[REG_W-1:0];   // Low word only

   //##################################################
   // Response build
   //##################################################

   // Posted writes get no response
   assign push = accept & group_match & (is_read | is_write);

   always_comb
   begin
      // Command copied, only the opcode changes
      push_data.cmd        = udev_req.cmd;
      push_data.cmd.opcode = is_read ? RESP_READ : RESP_WRITE;
      // Return to sender
      push_data.dstaddr    = udev_req.srcaddr;
      push_data.srcaddr    = '0;
      // Readback fills the whole data field
      if (is_read)
         push_data.data = {(UMI_DW/REG_W){reg_rddata}};
      else
         push_data.data = '0;                          // Write ack carries no data
   end

   //##################################################
   // Checks
   //##################################################

   // Bank sees at most one strobe per cycle
   a_strobe_onehot: assert property (@(posedge clk) disable iff (!nreset)
      !(reg_bus.read && reg_bus.write));

endmodule

// File: umi_reg_bank.sv
/*
 * Register array behind the register bus. Register 0 holds a fixed ID,
 * the rest are plain read/write. Readback is combinational so the
 * translator can build a read response in the strobe cycle.
 */

`timescale 1ns/100ps

module umi_reg_bank
  (
   input  logic                        clk,
   input  logic                        nreset,
   input  regif_pkg::reg_bus_t         reg_bus,
   output logic [regif_pkg::REG_W-1:0] reg_rddata
   );

   import regif_pkg::*;

   logic [REG_W-1:0]            regs [1:NUM_REGS-1];   // Reg 0 is the fixed ID, not stored
   logic [$clog2(NUM_REGS)-1:0] idx;   // Word index

   // Word aligned, byte offset ignored
   assign idx = reg_bus.addr[2 +: $clog2(NUM_REGS)];

   //##################################################
   // Register array
   //##################################################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         for (int i = 1; i < NUM_REGS; i++)
         begin
            regs[i] <= '0;
         end
      end
      else if (reg_bus.write && (idx != '0))   // Reg 0 is read only
      begin
         regs[idx] <= reg_bus.wrdata;
      end
   end

   //##################################################
   // Readback
   //##################################################

   // Valid whenever read is high, value otherwise ignored
   assign reg_rddata = (idx == '0) ? ID_VALUE : regs[idx];   // Reg 0 decoded to ID

   // Only single 32-bit words supported
   a_size_word: assert property (@(posedge clk) disable iff (!nreset)
      (reg_bus.read || reg_bus.write) |-> (reg_bus.size <= 3'd2));

endmodule

// File: umi_resp_fifo.sv
/*
 * Response queue between the translator and the UMI response port.
 * Holds RESP_DEPTH packets, presents the head with a valid/ready
 * handshake and raises full to stall new requests.
 */

`timescale 1ns/100ps

module umi_resp_fifo
  (
   input  logic               clk,
   input  logic               nreset,
   // Write side
   input  logic               push,
   input  umi_pkg::umi_resp_t push_data,
   output logic               full,
   // UMI response side
   output logic               udev_resp_valid,
   output umi_pkg::umi_resp_t udev_resp,
   input  logic               udev_resp_ready
   );

   import umi_pkg::*;
   import regif_pkg::*;

   umi_resp_t                         mem [RESP_DEPTH];   // Packet storage
   logic [$clog2(RESP_DEPTH)-1:0]     wr_ptr;
   logic [$clog2(RESP_DEPTH)-1:0]     rd_ptr;
   logic [$clog2(RESP_DEPTH+1)-1:0]   count;              // Entries held
   logic                              pop;

   assign pop = udev_resp_valid & udev_resp_ready;

   //##################################################
   // Storage
   //##################################################

   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= push_data;
   end

   //##################################################
   // Pointers and count
   //##################################################

   // Depth is a power of two, pointers wrap naturally
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;                          // Push with pop nets to zero
         endcase
      end
   end

   assign full            = (count == RESP_DEPTH);
   assign udev_resp_valid = (count != '0);
   assign udev_resp       = mem[rd_ptr];        // Head entry

   //##################################################
   // Checks
   //##################################################

   // Translator must respect full
   a_no_push_full: assert property (@(posedge clk) disable iff (!nreset)
      push |-> !full);

   // Stalled response holds until taken
   a_head_stable: assert property (@(posedge clk) disable iff (!nreset)
      (udev_resp_valid && !udev_resp_ready) |=> (udev_resp_valid && $stable(udev_resp)));

endmodule

// File: umi_regif_top.sv
/*
 * UMI register endpoint top level. Wires the request translator to the
 * register bank and the response queue. No logic lives here.
 */

`timescale 1ns/100ps

module umi_regif_top
  (
   input  logic               clk,
   input  logic               nreset,
   // UMI request
   input  logic               udev_req_valid,
   input  umi_pkg::umi_req_t  udev_req,
   output logic               udev_req_ready,
   // UMI response
   output logic               udev_resp_valid,
   output umi_pkg::umi_resp_t udev_resp,
   input  logic               udev_resp_ready
   );

   import umi_pkg::*;
   import regif_pkg::*;

   reg_bus_t         reg_bus;      // Translator to bank
   logic [REG_W-1:0] reg_rddata;   // Bank readback
   logic             push;
   umi_resp_t        push_data;
   logic             full;         // Queue to translator stall

   umi_regif u_regif (
      .clk            (clk),
      .nreset         (nreset),
      .udev_req_valid (udev_req_valid),
      .udev_req       (udev_req),
      .udev_req_ready (udev_req_ready),
      .full           (full),
      .reg_bus        (reg_bus),
      .reg_rddata     (reg_rddata),
      .push           (push),
      .push_data      (push_data)
   );

   umi_reg_bank u_reg_bank (
      .clk        (clk),
      .nreset     (nreset),
      .reg_bus    (reg_bus),
      .reg_rddata (reg_rddata)
   );

   umi_resp_fifo u_resp_fifo (
      .clk             (clk),
      .nreset          (nreset),
      .push            (push),
      .push_data       (push_data),
      .full            (full),
      .udev_resp_valid (udev_resp_valid),
      .udev_resp       (udev_resp),
      .udev_resp_ready (udev_resp_ready)
   );

endmodule

// File: tb_umi_regif.sv
/*
 * Testbench for the UMI register endpoint. Drives UMI requests into the
 * DUT, keeps a register model and a queue of expected responses, and
 * checks every response packet that leaves the response port.
 */

`timescale 1ns/100ps

module tb_umi_regif;

   import umi_pkg::*;
   import regif_pkg::*;

   localparam int NUM_RAND    = 400;                        // Random phase length
   localparam int WATCHDOG_NS = (NUM_RAND * 16 + 200) * 20;
   localparam int DRAIN_MAX   = 200;                        // Cycles to empty the queue

   logic      clk;
   logic      nreset;
   logic      udev_req_valid;
   umi_req_t  udev_req;
   logic      udev_req_ready;
   logic      udev_resp_valid;
   umi_resp_t udev_resp;
   logic      udev_resp_ready;

   logic [REG_W-1:0] model_regs [NUM_REGS];   // Register model, entry 0 unused
   umi_resp_t        exp_q [$];               // Expected responses in request order
   int               ready_mode;              // 0 high, 1 low, 2 random
   int               errors;
   int               checks;                  // Responses compared
   int               test_errors;             // Errors at start of current test
   int               num_tests;
   int               accepted;

   umi_regif_top u_umi_regif_top (
      .clk             (clk),
      .nreset          (nreset),
      .udev_req_valid  (udev_req_valid),
      .udev_req        (udev_req),
      .udev_req_ready  (udev_req_ready),
      .udev_resp_valid (udev_resp_valid),
      .udev_resp       (udev_resp),
      .udev_resp_ready (udev_resp_ready)
   );

   always #10 clk = ~clk;   // 20 ns period

   // Response ready pattern, changes on falling edge only
   always @(negedge clk)
   begin
      case (ready_mode)
         0:       udev_resp_ready = 1'b1;
         1:       udev_resp_ready = 1'b0;              // Held back-pressure
         default: udev_resp_ready = ($urandom % 2) != 0;
      endcase
   end

   //##################################################
   // Reference model and checks
   //##################################################

   task automatic report_mismatch(input string name, input logic [UMI_DW-1:0] exp,
                                  input logic [UMI_DW-1:0] act);
      $display("MISMATCH t=%0t %s exp=%h act=%h", $time, name, exp, act);
      errors++;
   endtask

   // Applies one accepted request to the model
   task automatic model_accept(input umi_req_t r);
      logic [3:0]       idx;
      logic             hit;
      logic [REG_W-1:0] rd;
      umi_resp_t        e;
      idx       = r.dstaddr[5:2];
      hit       = (r.dstaddr[GRP_OFFSET +: GRP_AW] == GRP_ID);
      rd        = (idx == 0) ? ID_VALUE : model_regs[idx];   // Value before this write
      e.cmd     = r.cmd;
      e.dstaddr = r.srcaddr;                                   // Back to the requester
      e.srcaddr = '0;
      e.data    = '0;
      if (hit && (r.cmd.opcode == REQ_WRITE || r.cmd.opcode == REQ_POSTED) && idx != 0)
         model_regs[idx] = r.data[REG_W-1:0];
      if (hit && r.cmd.opcode == REQ_READ)
      begin
         e.cmd.opcode = RESP_READ;
         e.data       = {rd, rd, rd, rd};                     // Word copied across data
         exp_q.push_back(e);
      end
      else if (hit && r.cmd.opcode == REQ_WRITE)
      begin
         e.cmd.opcode = RESP_WRITE;
         exp_q.push_back(e);
      end
   endtask

   task automatic check_resp(input umi_resp_t e, input umi_resp_t a);
      umi_cmd_t c;
      checks++;
      c        = a.cmd;
      c.opcode = e.cmd.opcode;                                 // Rest of command only
      if (a.cmd.opcode !== e.cmd.opcode)
         report_mismatch("udev_resp.cmd.opcode", e.cmd.opcode, a.cmd.opcode);
      if (c !== e.cmd)
         report_mismatch("udev_resp.cmd", e.cmd, c);
      if (a.dstaddr !== e.dstaddr)
         report_mismatch("udev_resp.dstaddr", e.dstaddr, a.dstaddr);
      if (a.srcaddr !== e.srcaddr)
         report_mismatch("udev_resp.srcaddr", e.srcaddr, a.srcaddr);
      if (a.data !== e.data)
         report_mismatch("udev_resp.data", e.data, a.data);
   endtask

   // Transfers seen at the rising edge, pre-edge values
   always @(posedge clk)
   begin
      if (nreset)
      begin
         if (udev_resp_valid && udev_resp_ready)
         begin
            if (exp_q.size() == 0)
            begin
               $display("ERROR t=%0t response arrived while none was expected", $time);
               errors++;
            end
            else
               check_resp(exp_q.pop_front(), udev_resp);
         end
         if (udev_req_valid && udev_req_ready)
            model_accept(udev_req);
      end
   end

   //##################################################
   // Stimulus helpers
   //##################################################

   function automatic umi_req_t make_req(input umi_opcode_e op, input logic hit,
                                         input logic [3:0] idx);
      umi_req_t r;
      r.cmd        = $urandom;                               // Random host, qos, prot...
      r.cmd.size   = 3'd2;                                   // One 32-bit word
      r.cmd.len    = 8'd0;
      r.cmd.opcode = op;
      r.dstaddr    = {$urandom, $urandom};
      r.srcaddr    = {$urandom, $urandom};
      r.data       = {$urandom, $urandom, $urandom, $urandom};
      if (hit)
         r.dstaddr[GRP_OFFSET +: GRP_AW] = GRP_ID;
      else
         r.dstaddr[GRP_OFFSET +: GRP_AW] = GRP_ID ^ (4'd1 + 4'($urandom_range(14, 0)));
      r.dstaddr[5:0] = {idx, 2'b00};                         // Word aligned
      return r;
   endfunction

   // Called on a falling edge, returns on the falling edge after the transfer
   task automatic send_req(input umi_req_t r);
      udev_req       = r;
      udev_req_valid = 1'b1;
      while (!udev_req_ready)      // Stable between rising edges
         @(negedge clk);
      @(negedge clk);
      udev_req_valid = 1'b0;
   endtask

   task automatic send_random();
      umi_opcode_e op;
      int          pick;
      pick = $urandom_range(3, 0);
      op   = (pick == 0) ? REQ_READ : (pick == 1) ? REQ_WRITE :
             (pick == 2) ? REQ_POSTED : REQ_ATOMIC;
      repeat ($urandom_range(3, 0)) @(negedge clk);          // Idle gap
      send_req(make_req(op, ($urandom_range(99, 0) < 80), 4'($urandom_range(15, 0))));
   endtask

   task automatic drain();
      int n;
      n = 0;
      while ((exp_q.size() != 0 || udev_resp_valid) && n < DRAIN_MAX)
      begin
         @(negedge clk);
         n++;
      end
      if (exp_q.size() != 0 || udev_resp_valid)
      begin
         $display("ERROR t=%0t responses did not drain, %0d still expected",
                  $time, exp_q.size());
         errors++;
      end
   endtask

   task automatic end_test(input string name);
      num_tests++;
      $display("test %0d %s done: %0d errors", num_tests, name, errors - test_errors);
      test_errors = errors;
   endtask

   //##################################################
   // Test sequence
   //##################################################

   initial
   begin
      void'($urandom(32'h74f3));
      clk             = 1'b0;
      nreset          = 1'b0;
      udev_req_valid  = 1'b0;
      udev_req        = '0;
      udev_resp_ready = 1'b1;
      ready_mode      = 0;
      errors          = 0;
      checks          = 0;
      test_errors     = 0;
      num_tests       = 0;
      for (int i = 0; i < NUM_REGS; i++)
         model_regs[i] = '0;
      repeat (3) @(negedge clk);                             // Three reset cycles
      nreset = 1'b1;

      // Idle outputs, then the ID word
      if (udev_resp_valid !== 1'b0)
         report_mismatch("udev_resp_valid", 0, udev_resp_valid);
      if (udev_req_ready !== 1'b1)
         report_mismatch("udev_req_ready", 1, udev_req_ready);
      send_req(make_req(REQ_READ, 1'b1, 4'd0));
      drain();
      end_test("reset_and_id");

      for (int i = 0; i < NUM_REGS; i++)                     // Reg 0 write must not stick
      begin
         send_req(make_req(REQ_WRITE, 1'b1, 4'(i)));
         send_req(make_req(REQ_READ, 1'b1, 4'(i)));
      end
      drain();
      end_test("write_readback");

      repeat (40)
         send_req(make_req(($urandom % 2) != 0 ? REQ_READ : REQ_WRITE, 1'b1,
                           4'($urandom_range(15, 0))));
      drain();
      end_test("response_fields");

      // Posted write lands, the others leave no trace
      ready_mode = 1;                                        // Keep any stray response queued
      @(negedge clk);
      send_req(make_req(REQ_POSTED, 1'b1, 4'd5));
      send_req(make_req(REQ_WRITE, 1'b0, 4'd5));
      send_req(make_req(REQ_ATOMIC, 1'b1, 4'd5));
      send_req(make_req(REQ_READ, 1'b0, 4'd7));
      repeat (4) @(negedge clk);
      if (udev_resp_valid !== 1'b0)
         report_mismatch("udev_resp_valid", 0, udev_resp_valid);
      ready_mode = 0;
      send_req(make_req(REQ_READ, 1'b1, 4'd5));
      drain();
      end_test("dropped_requests");

      ready_mode = 1;
      repeat (2) @(negedge clk);
      accepted = 0;
      while (udev_req_ready && accepted <= RESP_DEPTH)       // One read per cycle
      begin
         udev_req       = make_req(REQ_READ, 1'b1, 4'($urandom_range(15, 0)));
         udev_req_valid = 1'b1;
         @(negedge clk);
         accepted++;
      end
      udev_req_valid = 1'b0;
      if (accepted != RESP_DEPTH)
      begin
         $display("ERROR t=%0t %0d requests taken under back-pressure, expected %0d",
                  $time, accepted, RESP_DEPTH);
         errors++;
      end
      ready_mode = 0;
      drain();
      end_test("backpressure");

      ready_mode = 2;
      repeat (NUM_RAND)
         send_random();
      drain();
      end_test("random_traffic");

      $display("summary: %0d tests, %0d responses checked, %0d errors",
               num_tests, checks, errors);
      if (errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("ERROR t=%0t watchdog timed out before the tests finished", $time);
      $display("sim failed");
      $finish;
   end

endmodule

// File: build.f
umi_pkg.sv
regif_pkg.sv
umi_regif.sv
umi_reg_bank.sv
umi_resp_fifo.sv
umi_regif_top.sv
tb_umi_regif.sv

// File: Makefile
# Verilator build and run of the UMI register endpoint testbench

TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal -j 0
TOP   = tb_umi_regif
FLIST = build.f
OBJ   = obj_dir
LOG   = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(TOOL), run $(TOP), log to $(LOG)"
	@echo "  clean  remove $(OBJ) and $(LOG)"
	@echo "  help   show this list"

# Result comes from the log, the binary status alone is not enough
test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then \
		echo "FAIL: see $(LOG)"; exit 1; fi
	@if ! grep -q "sim passed" $(LOG); then \
		echo "FAIL: run ended early, see $(LOG)"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ) $(LOG)
